// ==== src/id_pkg.sv ====
package id_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int ALU_MODE_W    = 5;   // {funct7[0], funct7[5], funct3}
    localparam int ALU_OP1_SEL_W = 2;
    localparam int ALU_OP2_SEL_W = 3;
    localparam int MA_MODE_W     = 2;
    localparam int MA_SIZE_W     = 2;
    localparam int WB_SRC_W      = 2;
    localparam int PC_MODE_W     = 2;

    localparam logic [ALU_OP1_SEL_W-1:0] ALU_OP1_ZERO = 2'd0;
    localparam logic [ALU_OP1_SEL_W-1:0] ALU_OP1_RS1  = 2'd1;
    localparam logic [ALU_OP1_SEL_W-1:0] ALU_OP1_IMMU = 2'd2;

    localparam logic [ALU_OP2_SEL_W-1:0] ALU_OP2_ZERO = 3'd0;
    localparam logic [ALU_OP2_SEL_W-1:0] ALU_OP2_RS2  = 3'd1;
    localparam logic [ALU_OP2_SEL_W-1:0] ALU_OP2_IMMI = 3'd2;
    localparam logic [ALU_OP2_SEL_W-1:0] ALU_OP2_IMMS = 3'd3;
    localparam logic [ALU_OP2_SEL_W-1:0] ALU_OP2_PC   = 3'd4;

    localparam logic [ALU_MODE_W-1:0] ALU_ADD   = 5'b00000;
    localparam logic [ALU_MODE_W-1:0] ALU_COPY1 = 5'b11111;   // no rv32 op lands here

    localparam logic [MA_MODE_W-1:0] MA_NONE  = 2'd0;
    localparam logic [MA_MODE_W-1:0] MA_LOAD  = 2'd1;
    localparam logic [MA_MODE_W-1:0] MA_STORE = 2'd2;

    localparam logic [MA_SIZE_W-1:0] MA_SIZE_WORD = 2'b10;   // same code as funct3 of sw

    localparam logic [WB_SRC_W-1:0] WB_NONE = 2'd0;
    localparam logic [WB_SRC_W-1:0] WB_ALU  = 2'd1;
    localparam logic [WB_SRC_W-1:0] WB_MEM  = 2'd2;
    localparam logic [WB_SRC_W-1:0] WB_PC4  = 2'd3;

    localparam logic [PC_MODE_W-1:0] PC_NEXT     = 2'd0;
    localparam logic [PC_MODE_W-1:0] PC_JUMP_REL = 2'd1;
    localparam logic [PC_MODE_W-1:0] PC_JUMP_ABS = 2'd2;
    localparam logic [PC_MODE_W-1:0] PC_BRANCH   = 2'd3;

    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_PRIV    = 3'b000;   // ecall, ebreak

    // bubble values
    localparam logic [XLEN-1:0] NOP_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_IR = 32'h0000_0013;   // addi x0, x0, 0

    // one instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// ==== src/id_decoder.sv ====
module id_decoder (
    input  logic [id_pkg::XLEN-1:0]          ir_i,
    output logic [id_pkg::REG_ADDR_W-1:0]    rs1_o,
    output logic [id_pkg::REG_ADDR_W-1:0]    rs2_o,
    output logic [id_pkg::REG_ADDR_W-1:0]    rd_o,
    output logic [id_pkg::ALU_OP1_SEL_W-1:0] alu_op1_sel_o,
    output logic [id_pkg::ALU_OP2_SEL_W-1:0] alu_op2_sel_o,
    output logic [id_pkg::ALU_MODE_W-1:0]    alu_mode_o,
    output logic [id_pkg::MA_MODE_W-1:0]     ma_mode_o,
    output logic [id_pkg::MA_SIZE_W-1:0]     ma_size_o,
    output logic [id_pkg::WB_SRC_W-1:0]      wb_src_o,
    output logic [id_pkg::PC_MODE_W-1:0]     pc_mode_o,
    output logic [2:0]                       branch_f3_o,
    output logic [id_pkg::XLEN-1:0]          imm_i_o,
    output logic [id_pkg::XLEN-1:0]          imm_s_o,
    output logic [id_pkg::XLEN-1:0]          imm_u_o,
    output logic [id_pkg::XLEN-1:0]          jmp_offset_o,
    output logic                             ra_used_o,
    output logic                             rb_used_o,
    output logic                             halt_o
);
    import id_pkg::*;

    localparam int CW_W = PC_MODE_W + ALU_OP1_SEL_W + ALU_OP2_SEL_W + ALU_MODE_W
                        + MA_MODE_W + WB_SRC_W + 3;

    instr_u                ir_w;
    logic [6:0]            opc_w;
    logic [2:0]            f3_w;
    logic [XLEN-1:0]       imm_b_w;
    logic [XLEN-1:0]       imm_j_w;
    logic [ALU_MODE_W-1:0] mode7_w;
    logic [ALU_MODE_W-1:0] mode_imm_w;
    logic [CW_W-1:0]       cw_w;

    assign ir_w        = ir_i;
    assign opc_w       = ir_w.r.opcode;
    assign f3_w        = ir_w.r.funct3;
    assign rs1_o       = ir_w.r.rs1;
    assign rs2_o       = ir_w.r.rs2;
    assign rd_o        = ir_w.r.rd;
    assign branch_f3_o = f3_w;

    // sign always comes from ir[31]
    assign imm_i_o = {{20{ir_w.i.imm[11]}}, ir_w.i.imm};
    assign imm_s_o = {{20{ir_w.s.imm_hi[6]}}, ir_w.s.imm_hi, ir_w.s.imm_lo};
    assign imm_b_w = {{20{ir_w.b.imm_12}}, ir_w.b.imm_11, ir_w.b.imm_10_5, ir_w.b.imm_4_1, 1'b0};
    assign imm_u_o = {ir_w.u.imm, 12'b0};
    assign imm_j_w = {{12{ir_w.j.imm_20}}, ir_w.j.imm_19_12, ir_w.j.imm_11, ir_w.j.imm_10_1, 1'b0};

    assign mode7_w    = {ir_w.r.funct7[0], ir_w.r.funct7[5], f3_w};
    assign mode_imm_w = (f3_w == F3_SRL_SRA) ? mode7_w : {2'b00, f3_w};   // srai needs f7[5]

    // pc mode, op1, op2, alu mode, mem mode, wb source, {halt, ra used, rb used}
    always_comb begin
        casez ({f3_w, opc_w})
            {3'b???, OPC_OP_IMM}:
                cw_w = {PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMI, mode_imm_w, MA_NONE, WB_ALU, 3'b010};
            {3'b???, OPC_LUI}:
                cw_w = {PC_NEXT, ALU_OP1_IMMU, ALU_OP2_ZERO, ALU_COPY1, MA_NONE, WB_ALU, 3'b000};
            {3'b???, OPC_AUIPC}:
                cw_w = {PC_NEXT, ALU_OP1_IMMU, ALU_OP2_PC, ALU_ADD, MA_NONE, WB_ALU, 3'b000};
            {3'b???, OPC_OP}:
                cw_w = {PC_NEXT, ALU_OP1_RS1, ALU_OP2_RS2, mode7_w, MA_NONE, WB_ALU, 3'b011};
            {3'b???, OPC_JAL}:
                cw_w = {PC_JUMP_REL, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_PC4, 3'b000};
            {3'b???, OPC_JALR}:
                cw_w = {PC_JUMP_ABS, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_PC4, 3'b010};
            {F3_BEQ, OPC_BRANCH}, {F3_BNE, OPC_BRANCH}, {F3_BLT, OPC_BRANCH},
            {F3_BGE, OPC_BRANCH}, {F3_BLTU, OPC_BRANCH}, {F3_BGEU, OPC_BRANCH}:
                cw_w = {PC_BRANCH, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_NONE, 3'b011};
            {3'b???, OPC_LOAD}:
                cw_w = {PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMI, ALU_ADD, MA_LOAD, WB_MEM, 3'b010};
            {3'b???, OPC_STORE}:   // rs2 carries the store data
                cw_w = {PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMS, ALU_ADD, MA_STORE, WB_NONE, 3'b011};
            {3'b???, OPC_MISC_MEM}:
                cw_w = {PC_NEXT, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_NONE, 3'b000};
            {F3_PRIV, OPC_SYSTEM}:
                cw_w = {PC_NEXT, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_NONE, 3'b100};
            default:   // csr ops included, the stage has no csr path
                cw_w = {PC_NEXT, ALU_OP1_ZERO, ALU_OP2_ZERO, ALU_ADD, MA_NONE, WB_NONE, 3'b100};
        endcase
    end

    assign {pc_mode_o, alu_op1_sel_o, alu_op2_sel_o, alu_mode_o, ma_mode_o, wb_src_o,
            halt_o, ra_used_o, rb_used_o} = cw_w;

    assign ma_size_o = (opc_w == OPC_STORE) ? f3_w[1:0] : MA_SIZE_WORD;

    always_comb begin
        case (opc_w)
            OPC_JAL:  jmp_offset_o = imm_j_w;
            OPC_JALR: jmp_offset_o = imm_i_o;
            default:  jmp_offset_o = imm_b_w;   // only read in branch mode
        endcase
    end

endmodule

// ==== src/id_regfile.sv ====
module id_regfile #(
    parameter int REG_COUNT = 32   // 16 for rv32e
) (
    input  logic                          clk_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rd1_addr_i,
    output logic [id_pkg::XLEN-1:0]       rd1_data_o,
    input  logic [id_pkg::REG_ADDR_W-1:0] rd2_addr_i,
    output logic [id_pkg::XLEN-1:0]       rd2_data_o,
    input  logic [id_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [id_pkg::XLEN-1:0]       wr_data_i,
    input  logic                          wr_en_i
);
    import id_pkg::*;

    logic [XLEN-1:0] regs_r [1:REG_COUNT-1];   // x0 has no storage

    // x0 and addresses past the file are not backed
    function automatic logic present(input logic [REG_ADDR_W-1:0] addr);
        return (addr != '0) && (32'(addr) < REG_COUNT);
    endfunction

    always_ff @(posedge clk_i) begin
        if (wr_en_i && present(wr_addr_i)) begin
            regs_r[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd1_data_o = present(rd1_addr_i) ? regs_r[rd1_addr_i] : '0;
    assign rd2_data_o = present(rd2_addr_i) ? regs_r[rd2_addr_i] : '0;

    // an X address would hit an unknown register
    assert property (@(posedge clk_i) wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

// ==== src/id_operand_bypass.sv ====
module id_operand_bypass (
    input  logic [id_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                          ra_used_i,
    input  logic                          rb_used_i,
    input  logic [id_pkg::XLEN-1:0]       rf_ra_i,
    input  logic [id_pkg::XLEN-1:0]       rf_rb_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       ex_wb_data_i,
    input  logic                          ex_wb_valid_i,
    input  logic                          ex_wb_ready_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ma_wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       ma_wb_data_i,
    input  logic                          ma_wb_valid_i,
    input  logic                          ma_wb_ready_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       wb_data_i,
    input  logic                          wb_valid_i,
    output logic [id_pkg::XLEN-1:0]       ra_o,
    output logic [id_pkg::XLEN-1:0]       rb_o,
    output logic                          hazard_o
);
    import id_pkg::*;

    // youngest producer wins: ex, then ma, then wb
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       rf
    );
        if (rs == '0)
            return rf;   // file gives zero
        else if (ex_wb_valid_i && rs == ex_wb_addr_i)
            return ex_wb_data_i;
        else if (ma_wb_valid_i && rs == ma_wb_addr_i)
            return ma_wb_data_i;
        else if (wb_valid_i && rs == wb_addr_i)
            return wb_data_i;   // same-cycle write not yet in the file
        else
            return rf;
    endfunction

    // producer in flight whose result does not exist yet
    function automatic logic pending(
        input logic [REG_ADDR_W-1:0] rs,
        input logic                  used
    );
        return used && (rs != '0)
            && ((ex_wb_valid_i && !ex_wb_ready_i && rs == ex_wb_addr_i)
             || (ma_wb_valid_i && !ma_wb_ready_i && rs == ma_wb_addr_i));
    endfunction

    always_comb begin
        ra_o     = forward(rs1_i, rf_ra_i);
        rb_o     = forward(rs2_i, rf_rb_i);
        hazard_o = pending(rs1_i, ra_used_i) || pending(rs2_i, rb_used_i);
    end

endmodule

// ==== src/id_branch_unit.sv ====
module id_branch_unit (
    input  logic                         reset_i,
    input  logic [id_pkg::XLEN-1:0]      pc_i,
    input  logic [id_pkg::PC_MODE_W-1:0] pc_mode_i,
    input  logic [2:0]                   branch_f3_i,
    input  logic [id_pkg::XLEN-1:0]      jmp_offset_i,
    input  logic [id_pkg::XLEN-1:0]      ra_i,
    input  logic [id_pkg::XLEN-1:0]      rb_i,
    output logic                         jmp_valid_o,
    output logic [id_pkg::XLEN-1:0]      jmp_addr_o
);
    import id_pkg::*;

    logic cond_w;

    always_comb begin
        case (branch_f3_i[2:1])
            2'b00:   cond_w = (ra_i == rb_i);
            2'b10:   cond_w = ($signed(ra_i) < $signed(rb_i));
            2'b11:   cond_w = (ra_i < rb_i);
            default: cond_w = 1'b0;   // 01x never decodes as a branch
        endcase
    end

    always_comb begin
        jmp_valid_o = 1'b0;
        jmp_addr_o  = '0;
        if (!reset_i) begin
            case (pc_mode_i)
                PC_JUMP_REL: begin
                    jmp_valid_o = 1'b1;
                    jmp_addr_o  = pc_i + jmp_offset_i;
                end
                PC_JUMP_ABS: begin
                    jmp_valid_o = 1'b1;
                    jmp_addr_o  = ra_i + jmp_offset_i;   // jalr
                end
                PC_BRANCH: begin
                    jmp_valid_o = cond_w ^ branch_f3_i[0];   // odd funct3 inverts
                    jmp_addr_o  = pc_i + jmp_offset_i;
                end
                default: ;   // PC_NEXT
            endcase
        end
    end

endmodule

// ==== src/id_stage.sv ====
module id_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [id_pkg::XLEN-1:0]       pc_i,
    input  logic [id_pkg::XLEN-1:0]       ir_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       ex_wb_data_i,
    input  logic                          ex_wb_valid_i,
    input  logic                          ex_wb_ready_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ma_wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       ma_wb_data_i,
    input  logic                          ma_wb_valid_i,
    input  logic                          ma_wb_ready_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]       wb_data_i,
    input  logic                          wb_valid_i,
    output logic                          ready_o,
    output logic                          jmp_valid_o,
    output logic [id_pkg::XLEN-1:0]       jmp_addr_o,
    output logic [id_pkg::XLEN-1:0]       pc_o,
    output logic [id_pkg::XLEN-1:0]       ir_o,
    output logic [id_pkg::XLEN-1:0]       alu_op1_o,
    output logic [id_pkg::XLEN-1:0]       alu_op2_o,
    output logic [id_pkg::ALU_MODE_W-1:0] alu_mode_o,
    output logic [id_pkg::MA_MODE_W-1:0]  ma_mode_o,
    output logic [id_pkg::MA_SIZE_W-1:0]  ma_size_o,
    output logic [id_pkg::XLEN-1:0]       ma_data_o,
    output logic [id_pkg::WB_SRC_W-1:0]   wb_src_o,
    output logic [id_pkg::XLEN-1:0]       wb_link_o,
    output logic                          wb_valid_o,
    output logic                          halt_o
);
    import id_pkg::*;

    logic [REG_ADDR_W-1:0]    rs1_w, rs2_w, rd_w;
    logic [ALU_OP1_SEL_W-1:0] op1_sel_w;
    logic [ALU_OP2_SEL_W-1:0] op2_sel_w;
    logic [ALU_MODE_W-1:0]    alu_mode_w;
    logic [MA_MODE_W-1:0]     ma_mode_w;
    logic [MA_SIZE_W-1:0]     ma_size_w;
    logic [WB_SRC_W-1:0]      wb_src_w;
    logic [PC_MODE_W-1:0]     pc_mode_w;
    logic [2:0]               branch_f3_w;
    logic [XLEN-1:0]          imm_i_w, imm_s_w, imm_u_w, jmp_offset_w;
    logic [XLEN-1:0]          rf_ra_w, rf_rb_w, ra_w, rb_w;
    logic [XLEN-1:0]          op1_w, op2_w;
    logic                     ra_used_w, rb_used_w, halt_w;
    logic                     hazard_w;
    logic                     wb_valid_w;

    id_decoder decoder0 (
        .ir_i          (ir_i),
        .rs1_o         (rs1_w),
        .rs2_o         (rs2_w),
        .rd_o          (rd_w),
        .alu_op1_sel_o (op1_sel_w),
        .alu_op2_sel_o (op2_sel_w),
        .alu_mode_o    (alu_mode_w),
        .ma_mode_o     (ma_mode_w),
        .ma_size_o     (ma_size_w),
        .wb_src_o      (wb_src_w),
        .pc_mode_o     (pc_mode_w),
        .branch_f3_o   (branch_f3_w),
        .imm_i_o       (imm_i_w),
        .imm_s_o       (imm_s_w),
        .imm_u_o       (imm_u_w),
        .jmp_offset_o  (jmp_offset_w),
        .ra_used_o     (ra_used_w),
        .rb_used_o     (rb_used_w),
        .halt_o        (halt_w)
    );

    id_regfile #(.REG_COUNT(REG_COUNT)) regfile0 (
        .clk_i      (clk_i),
        .rd1_addr_i (rs1_w),
        .rd1_data_o (rf_ra_w),
        .rd2_addr_i (rs2_w),
        .rd2_data_o (rf_rb_w),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_valid_i)
    );

    id_operand_bypass bypass0 (
        .rs1_i         (rs1_w),
        .rs2_i         (rs2_w),
        .ra_used_i     (ra_used_w),
        .rb_used_i     (rb_used_w),
        .rf_ra_i       (rf_ra_w),
        .rf_rb_i       (rf_rb_w),
        .ex_wb_addr_i  (ex_wb_addr_i),
        .ex_wb_data_i  (ex_wb_data_i),
        .ex_wb_valid_i (ex_wb_valid_i),
        .ex_wb_ready_i (ex_wb_ready_i),
        .ma_wb_addr_i  (ma_wb_addr_i),
        .ma_wb_data_i  (ma_wb_data_i),
        .ma_wb_valid_i (ma_wb_valid_i),
        .ma_wb_ready_i (ma_wb_ready_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .wb_valid_i    (wb_valid_i),
        .ra_o          (ra_w),
        .rb_o          (rb_w),
        .hazard_o      (hazard_w)
    );

    id_branch_unit branch0 (
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .pc_mode_i    (pc_mode_w),
        .branch_f3_i  (branch_f3_w),
        .jmp_offset_i (jmp_offset_w),
        .ra_i         (ra_w),
        .rb_i         (rb_w),
        .jmp_valid_o  (jmp_valid_o),
        .jmp_addr_o   (jmp_addr_o)
    );

    always_comb begin
        case (op1_sel_w)
            ALU_OP1_RS1:  op1_w = ra_w;
            ALU_OP1_IMMU: op1_w = imm_u_w;
            default:      op1_w = '0;
        endcase
        case (op2_sel_w)
            ALU_OP2_RS2:  op2_w = rb_w;
            ALU_OP2_IMMI: op2_w = imm_i_w;
            ALU_OP2_IMMS: op2_w = imm_s_w;
            ALU_OP2_PC:   op2_w = pc_i;
            default:      op2_w = '0;
        endcase
    end

    assign wb_valid_w = (wb_src_w != WB_NONE) && (rd_w != '0);   // x0 writes dropped here
    assign ready_o    = reset_i || !hazard_w;   // fetch holds pc/ir while low

    always_ff @(posedge clk_i) begin
        if (reset_i || hazard_w) begin   // bubble, addi x0, x0, 0
            pc_o       <= NOP_PC;
            ir_o       <= NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= ALU_ADD;
            ma_mode_o  <= MA_NONE;
            ma_size_o  <= MA_SIZE_WORD;
            ma_data_o  <= '0;
            wb_src_o   <= WB_NONE;
            wb_link_o  <= '0;
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_op1_o  <= op1_w;
            alu_op2_o  <= op2_w;
            alu_mode_o <= alu_mode_w;
            ma_mode_o  <= ma_mode_w;
            ma_size_o  <= ma_size_w;
            ma_data_o  <= rb_w;   // store data
            wb_src_o   <= wb_src_w;
            wb_link_o  <= pc_i + 32'd4;
            wb_valid_o <= wb_valid_w;
            halt_o     <= halt_w;
        end
    end

    // fetch keeps the stalled instruction in place
    assert property (@(posedge clk_i) disable iff (reset_i)
        !ready_o |=> $stable(pc_i) && $stable(ir_i));

endmodule

// ==== verification/id_stage_tests.svh ====
// standard rv32i encodings
function automatic logic [XLEN-1:0] encode_i_type(input logic [11:0] imm,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [XLEN-1:0] encode_r_type(input logic [6:0] f7,
        input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [XLEN-1:0] encode_s_type(input logic [11:0] imm,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [XLEN-1:0] encode_b_type(input logic [12:0] imm,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [XLEN-1:0] encode_u_type(input logic [19:0] imm,
        input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [XLEN-1:0] encode_j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    wb_addr_i  = addr;
    wb_data_i  = data;
    wb_valid_i = 1'b1;
    tick();
    wb_valid_i = 1'b0;
endtask

task automatic issue(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] ir);
    pc_i = pc;
    ir_i = ir;
    tick();   // bundle is registered on this edge
endtask

task automatic check_alu(input string what, input logic [XLEN-1:0] op1,
        input logic [XLEN-1:0] op2, input logic [ALU_MODE_W-1:0] mode, input logic wbv);
    compare_word({what, " alu_op1_o"}, op1, alu_op1_o);
    compare_word({what, " alu_op2_o"}, op2, alu_op2_o);
    compare_mode({what, " alu_mode_o"}, mode, alu_mode_o);
    compare_bit({what, " wb_valid_o"}, wbv, wb_valid_o);
endtask

// jump outputs are combinational, sampled mid cycle
task automatic check_jump(input string what, input logic [XLEN-1:0] ir, input logic taken,
        input logic [XLEN-1:0] target);
    pc_i = 32'h0000_0100;
    ir_i = ir;
    #2;
    compare_bit({what, " jmp_valid_o"}, taken, jmp_valid_o);
    compare_word({what, " jmp_addr_o"}, target, jmp_addr_o);
    tick();
endtask

task automatic test_reset();
    begin_test("reset");
    #2;
    compare_word("pc_o", NOP_PC, pc_o);
    compare_word("ir_o", NOP_IR, ir_o);
    compare_word("alu_op1_o", '0, alu_op1_o);
    compare_word("alu_op2_o", '0, alu_op2_o);
    compare_mode("alu_mode_o", ALU_ADD, alu_mode_o);
    compare_field("ma_mode_o", MA_NONE, ma_mode_o);
    compare_field("wb_src_o", WB_NONE, wb_src_o);
    compare_bit("wb_valid_o", 1'b0, wb_valid_o);
    compare_bit("halt_o", 1'b0, halt_o);
    compare_bit("ready_o", 1'b1, ready_o);
    compare_bit("jmp_valid_o", 1'b0, jmp_valid_o);
    tick();
    end_test();
endtask

task automatic test_regfile_decode();
    logic [XLEN-1:0] x5_val;
    logic [XLEN-1:0] x6_val;
    begin_test("regfile_decode");
    x5_val = $random(seed);
    x6_val = $random(seed);
    write_reg(5'd5, x5_val);
    write_reg(5'd6, x6_val);
    issue(32'h0000_0040, encode_i_type(12'hF9C, 5'd5, 3'b000, 5'd7, OPC_OP_IMM));
    check_alu("addi", x5_val, 32'hFFFF_FF9C, 5'b00000, 1'b1);
    issue(32'h0000_0044, encode_r_type(7'b0100000, 5'd6, 5'd5, 3'b000, 5'd8));
    check_alu("sub", x5_val, x6_val, 5'b01000, 1'b1);   // funct7 bit 5 lands in mode bit 3
    issue(32'h0000_0048, encode_u_type(20'h12345, 5'd0, OPC_LUI));
    check_alu("lui", 32'h1234_5000, 32'h0, ALU_COPY1, 1'b0);   // rd x0, no write back
    issue(32'h0000_004C, encode_u_type(20'hABCDE, 5'd9, OPC_AUIPC));
    check_alu("auipc", 32'hABCD_E000, 32'h0000_004C, ALU_ADD, 1'b1);
    compare_word("auipc wb_link_o", 32'h0000_0050, wb_link_o);
    end_test();
endtask

task automatic test_forwarding();
    logic [XLEN-1:0] add_ir;
    begin_test("forwarding");
    add_ir        = encode_r_type(7'b0, 5'd0, 5'd11, 3'b000, 5'd10);   // add x10, x11, x0
    ex_wb_addr_i  = 5'd11;
    ex_wb_data_i  = 32'h1111_1111;
    ex_wb_valid_i = 1'b1;
    ex_wb_ready_i = 1'b1;
    ma_wb_addr_i  = 5'd11;
    ma_wb_data_i  = 32'h2222_2222;
    ma_wb_valid_i = 1'b1;
    ma_wb_ready_i = 1'b1;
    wb_addr_i     = 5'd11;
    wb_data_i     = 32'h4444_4444;   // also lands in the file
    wb_valid_i    = 1'b1;
    issue(32'h0000_0080, add_ir);
    compare_word("ex over ma and wb", 32'h1111_1111, alu_op1_o);
    compare_word("rs2 x0", 32'h0, alu_op2_o);
    ex_wb_valid_i = 1'b0;
    issue(32'h0000_0084, add_ir);
    compare_word("ma over wb", 32'h2222_2222, alu_op1_o);
    ma_wb_valid_i = 1'b0;
    wb_data_i     = 32'h3333_3333;   // differs from the stored value
    issue(32'h0000_0088, add_ir);
    compare_word("wb same cycle", 32'h3333_3333, alu_op1_o);
    ex_wb_addr_i  = 5'd0;
    ex_wb_valid_i = 1'b1;
    ma_wb_addr_i  = 5'd0;
    ma_wb_valid_i = 1'b1;
    wb_addr_i     = 5'd0;
    issue(32'h0000_008C, encode_r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd10));
    compare_word("x0 op1", 32'h0, alu_op1_o);
    compare_word("x0 op2", 32'h0, alu_op2_o);
    ex_wb_valid_i = 1'b0;
    ma_wb_valid_i = 1'b0;
    wb_valid_i    = 1'b0;
    end_test();
endtask

task automatic test_hazard();
    logic [XLEN-1:0] addi_ir;
    begin_test("hazard");
    addi_ir       = encode_i_type(12'd5, 5'd13, 3'b000, 5'd12, OPC_OP_IMM);
    ex_wb_addr_i  = 5'd13;
    ex_wb_data_i  = 32'h0000_0700;
    ex_wb_valid_i = 1'b1;
    ex_wb_ready_i = 1'b0;   // result not produced yet
    pc_i          = 32'h0000_00C0;
    ir_i          = addi_ir;
    #2;
    compare_bit("ready_o in stall", 1'b0, ready_o);
    tick();
    compare_word("bubble pc_o", NOP_PC, pc_o);
    compare_word("bubble ir_o", NOP_IR, ir_o);
    compare_bit("bubble wb_valid_o", 1'b0, wb_valid_o);
    ex_wb_ready_i = 1'b1;
    #2;
    compare_bit("ready_o restored", 1'b1, ready_o);
    tick();
    compare_word("pc_o", 32'h0000_00C0, pc_o);
    compare_word("ir_o", addi_ir, ir_o);
    compare_word("forwarded op1", 32'h0000_0700, alu_op1_o);
    compare_word("op2", 32'h0000_0005, alu_op2_o);
    ex_wb_valid_i = 1'b0;
    end_test();
endtask

task automatic test_jumps();
    begin_test("jumps");
    write_reg(5'd20, 32'hFFFF_FFF0);   // -16, also huge unsigned
    write_reg(5'd21, 32'h0000_0005);
    check_jump("jal", encode_j_type(21'h000800, 5'd1), 1'b1, 32'h0000_0900);
    check_jump("jalr", encode_i_type(12'd12, 5'd21, 3'b000, 5'd1, OPC_JALR), 1'b1, 32'h11);
    check_jump("beq taken", encode_b_type(13'h1FF8, 5'd21, 5'd21, F3_BEQ), 1'b1, 32'hF8);
    check_jump("beq not", encode_b_type(13'h1FF8, 5'd20, 5'd21, F3_BEQ), 1'b0, 32'hF8);
    check_jump("bne taken", encode_b_type(13'h0010, 5'd20, 5'd21, F3_BNE), 1'b1, 32'h110);
    check_jump("bne not", encode_b_type(13'h0010, 5'd21, 5'd21, F3_BNE), 1'b0, 32'h110);
    check_jump("blt taken", encode_b_type(13'h0020, 5'd20, 5'd21, F3_BLT), 1'b1, 32'h120);
    check_jump("blt not", encode_b_type(13'h0020, 5'd21, 5'd20, F3_BLT), 1'b0, 32'h120);
    check_jump("bgeu taken", encode_b_type(13'h0040, 5'd20, 5'd21, F3_BGEU), 1'b1, 32'h140);
    check_jump("bgeu not", encode_b_type(13'h0040, 5'd21, 5'd20, F3_BGEU), 1'b0, 32'h140);
    end_test();
endtask

task automatic test_mem_halt();
    begin_test("mem_halt");
    issue(32'h0000_0140, encode_s_type(12'hFF8, 5'd20, 5'd21, 3'b001));   // sh x21, -8(x20)
    compare_field("sh ma_mode_o", MA_STORE, ma_mode_o);
    compare_field("sh ma_size_o", 2'b01, ma_size_o);
    compare_word("sh ma_data_o", 32'h0000_0005, ma_data_o);
    compare_word("sh alu_op2_o", 32'hFFFF_FFF8, alu_op2_o);
    compare_bit("sh wb_valid_o", 1'b0, wb_valid_o);
    issue(32'h0000_0144, encode_i_type(12'd4, 5'd20, 3'b010, 5'd23, OPC_LOAD));
    compare_field("lw ma_mode_o", MA_LOAD, ma_mode_o);
    compare_field("lw wb_src_o", WB_MEM, wb_src_o);
    compare_bit("lw halt_o", 1'b0, halt_o);
    issue(32'h0000_0148, 32'h0000_0073);   // ecall
    compare_bit("ecall halt_o", 1'b1, halt_o);
    issue(32'h0000_014C, 32'h0000_007F);   // opcode outside rv32i
    compare_bit("unknown halt_o", 1'b1, halt_o);
    end_test();
endtask

// ==== verification/id_stage_tb.sv ====
module id_stage_tb;
    import id_pkg::*;

    localparam int MAX_CYCLES = 400;   // tests use well under half of this

    logic                  clk_i;
    logic                  reset_i;
    logic [XLEN-1:0]       pc_i, ir_i;
    logic [REG_ADDR_W-1:0] ex_wb_addr_i, ma_wb_addr_i, wb_addr_i;
    logic [XLEN-1:0]       ex_wb_data_i, ma_wb_data_i, wb_data_i;
    logic                  ex_wb_valid_i, ex_wb_ready_i, ma_wb_valid_i, ma_wb_ready_i;
    logic                  wb_valid_i;
    logic                  ready_o, jmp_valid_o, wb_valid_o, halt_o;
    logic [XLEN-1:0]       jmp_addr_o, pc_o, ir_o, alu_op1_o, alu_op2_o, ma_data_o, wb_link_o;
    logic [ALU_MODE_W-1:0] alu_mode_o;
    logic [MA_MODE_W-1:0]  ma_mode_o;
    logic [MA_SIZE_W-1:0]  ma_size_o;
    logic [WB_SRC_W-1:0]   wb_src_o;

    int    seed = 32'h5f740ec5;
    int    cycle_count = 0;
    int    errors = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    string test_name = "";

    id_stage #(.REG_COUNT(32)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string what, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, got %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_mode(input string what, input logic [ALU_MODE_W-1:0] exp,
                                input logic [ALU_MODE_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %b, got %b", test_name, what, exp, act);
        end
    endtask

    // ma mode, ma size and wb source are all 2-bit codes
    task automatic compare_field(input string what, input logic [MA_MODE_W-1:0] exp,
                                 input logic [MA_MODE_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %b, got %b", test_name, what, exp, act);
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %b, got %b", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", test_name, errors - errors_at_start);
        end
    endtask

    // inputs change 1 unit after the edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    `include "id_stage_tests.svh"

    initial begin
        reset_i       = 1'b1;
        pc_i          = NOP_PC;
        ir_i          = NOP_IR;
        ex_wb_addr_i  = '0;
        ex_wb_data_i  = '0;
        ex_wb_valid_i = 1'b0;
        ex_wb_ready_i = 1'b0;
        ma_wb_addr_i  = '0;
        ma_wb_data_i  = '0;
        ma_wb_valid_i = 1'b0;
        ma_wb_ready_i = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        wb_valid_i    = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        test_reset();
        test_regfile_decode();
        test_forwarding();
        test_hazard();
        test_jumps();
        test_mem_halt();

        $display("summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verification
src/id_pkg.sv
src/id_decoder.sv
src/id_regfile.sv
src/id_operand_bypass.sv
src/id_branch_unit.sv
src/id_stage.sv
verification/id_stage_tb.sv

// ==== Makefile ====
all: run

obj_dir/Vid_stage_tb: sources.f $(wildcard src/*.sv) $(wildcard verification/*.sv*)
	verilator --binary --timing --assert -f sources.f --top-module id_stage_tb

run: obj_dir/Vid_stage_tb
	./obj_dir/Vid_stage_tb | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
